// File: build.f
source/fifo_pkg.sv
source/sdp_ram.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/fifo_top.sv
verif/fifo_tb.sv

// File: source/fifo_pkg.sv
//--------------------------------------------------------------------
// Byte FIFO shared definitions
// Sizes and the reset fill word of the FIFO, plus the request structs
// that the two controllers hand to the dual-port memory
//--------------------------------------------------------------------
package fifo_pkg;

    //----------------------------------------------------------------
    // Sizes
    //----------------------------------------------------------------
    localparam int DATA_W = 8;              // Bits per stored word
    localparam int DEPTH  = 16;             // Words in memory, power of two
    localparam int ADDR_W = $clog2(DEPTH);  // Memory address bits
    localparam int PTR_W  = ADDR_W + 1;     // Address plus wrap bit

    // Word loaded into every location on reset
    // Also seen on the read data while the read is disabled
    localparam logic [DATA_W-1:0] FILL_VALUE = 8'hFF;

    //----------------------------------------------------------------
    // Memory requests
    //----------------------------------------------------------------

    // Write port request from the write controller
    typedef struct packed {
        logic              en;    // Store strobe for this cycle
        logic [ADDR_W-1:0] addr;  // Target location
        logic [DATA_W-1:0] data;  // Word to store
    } wr_req_t;

    // Read port request from the read controller
    typedef struct packed {
        logic              en;    // Low gives FILL_VALUE on rdata
        logic [ADDR_W-1:0] addr;  // Head location
    } rd_req_t;

    // Write request is 1 + ADDR_W + DATA_W bits wide
    // Read request is 1 + ADDR_W bits wide

endpackage : fifo_pkg

// File: source/fifo_rd_ctrl.sv
//--------------------------------------------------------------------
// FIFO read controller
// Turns pop strobes into read addresses and shows the head word in
// show-ahead form; detects empty, counts occupancy and holds a
// sticky underflow flag
//--------------------------------------------------------------------
module fifo_rd_ctrl
    import fifo_pkg::*;
(
    input  logic             clka,       // Core clock
    input  logic             rstna,      // Async reset, active low
    //----------------------------------------------------------------
    // Consumer side
    //----------------------------------------------------------------
    input  logic             pop,        // Read strobe, one word
    output logic             empty,      // Nothing to pop
    output logic [PTR_W-1:0] count,      // Words held, 0 to DEPTH
    output logic             underflow,  // Sticky, pop seen while empty
    //----------------------------------------------------------------
    // Memory and write side
    //----------------------------------------------------------------
    input  logic [PTR_W-1:0] wr_ptr,     // From the write controller
    output rd_req_t          rd_req,     // To the memory read port
    output logic [PTR_W-1:0] rd_ptr      // To the write controller
);

    //----------------------------------------------------------------
    // Internal signals
    //----------------------------------------------------------------
    logic [ADDR_W-1:0] head_addr;  // Address part of rd_ptr
    logic              pop_ok;     // Pop accepted this cycle

    assign head_addr = rd_ptr[ADDR_W-1:0];

    // Both pointers on the same lap and slot
    assign empty = (rd_ptr == wr_ptr);

    // Modulo 2*DEPTH difference
    // The lap bit keeps full apart from empty, so DEPTH fits in PTR_W
    assign count = wr_ptr - rd_ptr;

    // Judged from the pointers before the edge
    // A push in the same cycle does not make this pop valid
    assign pop_ok = pop && !empty;

    //----------------------------------------------------------------
    // Read request
    //----------------------------------------------------------------

    // Head word is always presented while data is held
    // Combinational memory read gives show-ahead with no extra cycle
    assign rd_req.en   = !empty;     // Low parks rdata on FILL_VALUE
    assign rd_req.addr = head_addr;

    //----------------------------------------------------------------
    // Read pointer
    //----------------------------------------------------------------

    // Advancing the pointer retires the head word
    // Next word is on the read data right after the edge
    always_ff @(posedge clka or negedge rstna) begin
        if (!rstna) begin
            rd_ptr <= '0;
        end else if (pop_ok) begin
            rd_ptr <= rd_ptr + PTR_W'(1);  // Wraps through the lap bit
        end
    end

    //----------------------------------------------------------------
    // Underflow flag
    //----------------------------------------------------------------

    // Ignored pop is remembered until reset
    always_ff @(posedge clka or negedge rstna) begin
        if (!rstna) begin
            underflow <= 1'b0;
        end else if (pop && empty) begin
            underflow <= 1'b1;
        end
    end

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------

    // Occupancy rests on both controllers keeping their pointers in
    // step; a count past DEPTH means the writer lapped the reader
    count_in_range_a : assert property (
        @(posedge clka) disable iff (!rstna)
        count <= PTR_W'(DEPTH)
    ) else begin
        $error("fifo_rd_ctrl: count %0d exceeds depth %0d", count, DEPTH);
    end

    // Pointer widths
    // rd_ptr and wr_ptr are PTR_W bits, count shares the same width
    // head_addr drops the lap bit for the memory address

endmodule : fifo_rd_ctrl

// File: source/fifo_top.sv
//--------------------------------------------------------------------
// Byte FIFO top level
// Single-clock FIFO with show-ahead output
// Write controller and read controller around a dual-port memory
//--------------------------------------------------------------------
module fifo_top
    import fifo_pkg::*;
(
    input  logic              clka,       // Core clock
    input  logic              rstna,      // Async reset, active low
    //----------------------------------------------------------------
    // Producer side
    //----------------------------------------------------------------
    input  logic              push,       // Enqueue strobe
    input  logic [DATA_W-1:0] push_data,  // Word to enqueue
    output logic              full,       // Push would be dropped
    output logic              overflow,   // Sticky until reset
    //----------------------------------------------------------------
    // Consumer side
    //----------------------------------------------------------------
    input  logic              pop,        // Dequeue strobe
    output logic [DATA_W-1:0] pop_data,   // Head word, show-ahead
    output logic              empty,      // Pop would be ignored
    output logic [PTR_W-1:0]  count,      // Words held
    output logic              underflow   // Sticky until reset
);

    //----------------------------------------------------------------
    // Internal wiring
    //----------------------------------------------------------------
    wr_req_t          wr_req;  // Write controller to memory
    rd_req_t          rd_req;  // Read controller to memory
    logic [PTR_W-1:0] wr_ptr;  // Tail pointer with lap bit
    logic [PTR_W-1:0] rd_ptr;  // Head pointer with lap bit

    // Input side
    fifo_wr_ctrl u_wr_ctrl (
        .clka      (clka),
        .rstna     (rstna),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .overflow  (overflow),
        .rd_ptr    (rd_ptr),
        .wr_req    (wr_req),
        .wr_ptr    (wr_ptr)
    );

    // Storage, read data goes straight out as pop_data
    sdp_ram u_ram (
        .clka   (clka),
        .rstna  (rstna),
        .wr_req (wr_req),
        .rd_req (rd_req),
        .rdata  (pop_data)
    );

    // Output side
    fifo_rd_ctrl u_rd_ctrl (
        .clka      (clka),
        .rstna     (rstna),
        .pop       (pop),
        .empty     (empty),
        .count     (count),
        .underflow (underflow),
        .wr_ptr    (wr_ptr),
        .rd_req    (rd_req),
        .rd_ptr    (rd_ptr)
    );

endmodule : fifo_top

// File: source/fifo_wr_ctrl.sv
//--------------------------------------------------------------------
// FIFO write controller
// Turns push strobes into memory write requests, keeps the write
// pointer, detects full and holds a sticky overflow flag
//--------------------------------------------------------------------
module fifo_wr_ctrl
    import fifo_pkg::*;
(
    input  logic              clka,       // Core clock
    input  logic              rstna,      // Async reset, active low
    //----------------------------------------------------------------
    // Producer side
    //----------------------------------------------------------------
    input  logic              push,       // Write strobe, one word
    input  logic [DATA_W-1:0] push_data,  // Word to enqueue
    output logic              full,       // No room for another word
    output logic              overflow,   // Sticky, push seen while full
    //----------------------------------------------------------------
    // Memory and read side
    //----------------------------------------------------------------
    input  logic [PTR_W-1:0]  rd_ptr,     // From the read controller
    output wr_req_t           wr_req,     // To the memory write port
    output logic [PTR_W-1:0]  wr_ptr      // To the read controller
);

    //----------------------------------------------------------------
    // Internal signals
    //----------------------------------------------------------------
    logic [ADDR_W-1:0] wr_addr;   // Address part of wr_ptr
    logic [ADDR_W-1:0] rd_addr;   // Address part of rd_ptr
    logic              wrap_ne;   // Wrap bits differ
    logic              push_ok;   // Push accepted this cycle

    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign rd_addr = rd_ptr[ADDR_W-1:0];
    assign wrap_ne = wr_ptr[ADDR_W] ^ rd_ptr[ADDR_W];

    // Writer is one lap ahead of the reader at the same slot
    assign full = wrap_ne && (wr_addr == rd_addr);

    // Judged from the pointers before the edge
    // A pop in the same cycle does not free room for this push
    assign push_ok = push && !full;

    //----------------------------------------------------------------
    // Write request
    //----------------------------------------------------------------

    // Combinational so the store lands at the accepting edge
    assign wr_req.en   = push_ok;
    assign wr_req.addr = wr_addr;    // Current tail slot
    assign wr_req.data = push_data;

    //----------------------------------------------------------------
    // Write pointer
    //----------------------------------------------------------------
    always_ff @(posedge clka or negedge rstna) begin
        if (!rstna) begin
            wr_ptr <= '0;
        end else if (push_ok) begin
            wr_ptr <= wr_ptr + PTR_W'(1);  // Wraps through the lap bit
        end
    end

    //----------------------------------------------------------------
    // Overflow flag
    //----------------------------------------------------------------

    // Dropped push is remembered until reset
    always_ff @(posedge clka or negedge rstna) begin
        if (!rstna) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------

    // A full FIFO must never write, else the head word is overwritten
    // before the read controller has passed it on
    // Room judged from the pointer distance, which also catches a
    // reader that has run past the writer
    no_write_when_full_a : assert property (
        @(posedge clka) disable iff (!rstna)
        wr_req.en |-> ((wr_ptr - rd_ptr) < PTR_W'(DEPTH))
    ) else begin
        $error("fifo_wr_ctrl: write request issued while full");
    end

endmodule : fifo_wr_ctrl

// File: source/sdp_ram.sv
//--------------------------------------------------------------------
// Simple dual-port memory
// One clocked write port and one gated combinational read port
// Whole array filled with FILL_VALUE on asynchronous reset
//--------------------------------------------------------------------
module sdp_ram
    import fifo_pkg::*;
(
    //----------------------------------------------------------------
    // Write port
    //----------------------------------------------------------------
    input  logic              clka,    // Core clock
    input  logic              rstna,   // Async reset, active low
    input  wr_req_t           wr_req,  // Enable, address and data
    //----------------------------------------------------------------
    // Read port
    //----------------------------------------------------------------
    input  rd_req_t           rd_req,  // Enable and address
    output logic [DATA_W-1:0] rdata    // Word at rd_req.addr
);

    //----------------------------------------------------------------
    // Storage
    //----------------------------------------------------------------
    logic [DATA_W-1:0] mem [DEPTH];  // DEPTH words of DATA_W bits

    // Reset walks every location so the contents are known
    // Write takes effect at the rising edge where en is high
    always_ff @(posedge clka or negedge rstna) begin
        if (!rstna) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= FILL_VALUE;  // Known fill
            end
        end else if (wr_req.en) begin
            mem[wr_req.addr] <= wr_req.data;  // Single word store
        end
    end

    //----------------------------------------------------------------
    // Read path
    //----------------------------------------------------------------

    // No output register, so the word follows the address in the
    // same cycle
    // Disabled read parks the output on the fill word
    assign rdata = rd_req.en ? mem[rd_req.addr] : FILL_VALUE;

    // A read of the location being written in this cycle returns the
    // old word; the new one appears after the edge

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------

    // Enabled write must target a known location
    // An X address would smear the write over the array
    wr_addr_known_a : assert property (
        @(posedge clka) disable iff (!rstna)
        wr_req.en |-> !$isunknown(wr_req.addr)
    ) else begin
        $error("sdp_ram: write address unknown while write enabled");
    end

endmodule : sdp_ram

// File: verif/fifo_tb.sv
//--------------------------------------------------------------------
// Byte FIFO testbench
// Drives push and pop strobes into the FIFO top level, keeps a queue
// model of the expected contents and flags, and compares every cycle
// through concurrent assertions
//--------------------------------------------------------------------
module fifo_tb
    import fifo_pkg::*;
();

    //----------------------------------------------------------------
    // Test constants
    //----------------------------------------------------------------
    localparam int SEED        = 46;   // Fixed random seed
    localparam int WAIT_LIMIT  = 64;   // Cycles allowed per wait
    localparam int RAND_CYCLES = 400;  // Random traffic length
    localparam int NUM_TESTS   = 6;

    //----------------------------------------------------------------
    // DUT signals
    //----------------------------------------------------------------
    logic              clka;
    logic              rstna;
    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              pop;
    logic [DATA_W-1:0] pop_data;
    logic              full;
    logic              empty;
    logic [PTR_W-1:0]  count;
    logic              overflow;
    logic              underflow;

    // Reference model state
    logic [DATA_W-1:0] model_q[$];                 // Expected contents, head first
    logic [DATA_W-1:0] exp_pop_data = FILL_VALUE;
    logic [PTR_W-1:0]  exp_count    = '0;
    logic              exp_empty    = 1'b1;
    logic              exp_full     = 1'b0;
    logic              exp_ovf      = 1'b0;        // Sticky overflow
    logic              exp_unf      = 1'b0;        // Sticky underflow

    // Run bookkeeping
    int err_count  = 0;    // Assertion failures
    int pass_tests = 0;
    int fail_tests = 0;
    bit timed_out  = 1'b0;

    fifo_top u_dut (
        .clka      (clka),
        .rstna     (rstna),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .overflow  (overflow),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .count     (count),
        .underflow (underflow)
    );

    // Period of 100
    initial begin
        clka = 1'b0;
        forever #50 clka = ~clka;
    end

    //----------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------

    // Acceptance judged from the size before the edge, as the DUT does
    always @(posedge clka or negedge rstna) begin : ref_model
        int   size_before;
        logic take_pop;
        logic take_push;
        if (!rstna) begin
            model_q.delete();
            exp_ovf = 1'b0;
            exp_unf = 1'b0;
        end else begin
            size_before = model_q.size();
            take_pop    = pop && (size_before != 0);
            take_push   = push && (size_before != DEPTH);
            if (push && (size_before == DEPTH)) exp_ovf = 1'b1;  // Dropped push
            if (pop && (size_before == 0)) exp_unf = 1'b1;       // Ignored pop
            if (take_pop) void'(model_q.pop_front());
            if (take_push) model_q.push_back(push_data);
        end
        exp_count = PTR_W'(model_q.size());
        exp_empty = (model_q.size() == 0);
        exp_full  = (model_q.size() == DEPTH);
        if (model_q.size() == 0) begin
            exp_pop_data = FILL_VALUE;  // Read disabled while empty
        end else begin
            exp_pop_data = model_q[0];  // Show-ahead head word
        end
    end

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        err_count++;
        $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
    endtask

    chk_pop_data_a : assert property (@(posedge clka) disable iff (!rstna)
        pop_data == exp_pop_data)
        else report_mismatch("pop_data", $sampled(exp_pop_data), $sampled(pop_data));

    chk_empty_a : assert property (@(posedge clka) disable iff (!rstna)
        empty == exp_empty)
        else report_mismatch("empty", $sampled(exp_empty), $sampled(empty));

    chk_full_a : assert property (@(posedge clka) disable iff (!rstna)
        full == exp_full)
        else report_mismatch("full", $sampled(exp_full), $sampled(full));

    chk_count_a : assert property (@(posedge clka) disable iff (!rstna)
        count == exp_count)
        else report_mismatch("count", $sampled(exp_count), $sampled(count));

    chk_overflow_a : assert property (@(posedge clka) disable iff (!rstna)
        overflow == exp_ovf)
        else report_mismatch("overflow", $sampled(exp_ovf), $sampled(overflow));

    chk_underflow_a : assert property (@(posedge clka) disable iff (!rstna)
        underflow == exp_unf)
        else report_mismatch("underflow", $sampled(exp_unf), $sampled(underflow));

    //----------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------

    // Values take effect at the following rising edge
    task automatic step(input logic do_push, input logic [DATA_W-1:0] d,
                        input logic do_pop);
        @(posedge clka);
        push      <= do_push;
        push_data <= d;
        pop       <= do_pop;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) step(1'b0, '0, 1'b0);
    endtask

    // Mid-run reset, asserted and released on rising edges
    task automatic reset_dut(input int cycles);
        @(posedge clka);
        rstna <= 1'b0;
        repeat (cycles) @(posedge clka);
        rstna <= 1'b1;
    endtask

    task automatic push_words(input int n);
        repeat (n) step(1'b1, DATA_W'($urandom), 1'b0);
        idle(1);
    endtask

    task automatic pop_words(input int n);
        repeat (n) step(1'b0, '0, 1'b1);
        idle(1);
    endtask

    // Status read at the falling edge, away from the update
    task automatic wait_for_count(input int target, input string what);
        int n;
        n = 0;
        @(negedge clka);
        while (count != PTR_W'(target)) begin
            if (n >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: %s not reached within %0d cycles", what, WAIT_LIMIT);
                return;
            end
            n++;
            @(negedge clka);
        end
    endtask

    task automatic wait_for_full();
        int n;
        n = 0;
        @(negedge clka);
        while (!full) begin
            if (n >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: full did not rise within %0d cycles", WAIT_LIMIT);
                return;
            end
            n++;
            @(negedge clka);
        end
    endtask

    task automatic wait_for_empty();
        int n;
        n = 0;
        @(negedge clka);
        while (!empty) begin
            if (n >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: empty did not rise within %0d cycles", WAIT_LIMIT);
                return;
            end
            n++;
            @(negedge clka);
        end
    endtask

    //----------------------------------------------------------------
    // Tests
    //----------------------------------------------------------------
    task automatic reset_state_test();
        idle(3);                   // Idle outputs checked each edge
        wait_for_empty();
    endtask

    task automatic order_test();
        push_words(DEPTH);
        wait_for_full();
        if (timed_out) return;
        pop_words(DEPTH);          // Head compared on every edge
        wait_for_empty();
    endtask

    task automatic full_overflow_test();
        push_words(DEPTH);
        wait_for_full();
        if (timed_out) return;
        step(1'b1, 8'h5A, 1'b0);   // Push into a full FIFO
        idle(3);
        wait_for_count(DEPTH, "count at depth after dropped push");
    endtask

    task automatic empty_underflow_test();
        pop_words(DEPTH);          // Drain what the last test left
        wait_for_empty();
        if (timed_out) return;
        step(1'b0, '0, 1'b1);      // Pop from an empty FIFO
        idle(3);
        wait_for_count(0, "count at zero after ignored pop");
    endtask

    task automatic simultaneous_test();
        reset_dut(5);              // Sticky flags cleared for the full case
        push_words(DEPTH / 2);
        wait_for_count(DEPTH / 2, "half fill");
        if (timed_out) return;
        repeat (6) step(1'b1, DATA_W'($urandom), 1'b1);  // Level holds
        idle(1);
        wait_for_count(DEPTH / 2, "half fill after push and pop");
        if (timed_out) return;
        push_words(DEPTH / 2);
        wait_for_full();
        if (timed_out) return;
        step(1'b1, DATA_W'($urandom), 1'b1);  // Pop wins when full
        idle(1);
        wait_for_count(DEPTH - 1, "one below depth");
        if (timed_out) return;
        pop_words(DEPTH - 1);
        wait_for_empty();
    endtask

    task automatic random_test();
        repeat (RAND_CYCLES) begin
            step(1'($urandom % 2), DATA_W'($urandom), 1'($urandom % 2));
        end
        idle(2);
    endtask

    // One result line per test
    task automatic run_one(input int id);
        int    errs_before;
        string name;
        errs_before = err_count;
        case (id)
            0: begin
                name = "reset_state";
                reset_state_test();
            end
            1: begin
                name = "order_preserved";
                order_test();
            end
            2: begin
                name = "full_overflow";
                full_overflow_test();
            end
            3: begin
                name = "empty_underflow";
                empty_underflow_test();
            end
            4: begin
                name = "push_pop_together";
                simultaneous_test();
            end
            default: begin
                name = "random_traffic";
                random_test();
            end
        endcase
        if (timed_out || (err_count != errs_before)) begin
            fail_tests++;
            $display("Test %-18s failed, %0d errors", name, err_count - errs_before);
        end else begin
            pass_tests++;
            $display("Test %-18s ok", name);
        end
    endtask

    //----------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------
    initial begin
        void'($urandom(SEED));     // Single seed for the run
        rstna     = 1'b0;
        push      = 1'b0;
        push_data = '0;
        pop       = 1'b0;
        repeat (5) @(posedge clka);
        rstna <= 1'b1;             // Released on a rising edge

        for (int id = 0; (id < NUM_TESTS) && !timed_out; id++) begin
            run_one(id);
        end
        @(negedge clka);           // Let the last action blocks settle

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 pass_tests, fail_tests, err_count);
        if (!timed_out && (fail_tests == 0) && (err_count == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : fifo_tb
